/* hdl/uart_pkg.sv */
package uart_pkg;

	////////////////////
	// Serial link timing

	// Clock cycles per serial bit
	localparam int CLKS_PER_BIT = 16;
	// Data bits per frame, LSB first
	localparam int DATA_BITS = 8;

	////////////////////
	// Types

	typedef logic [DATA_BITS-1:0] uart_byte_t;
	// Cycle counter inside one bit period
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_cnt_t;
	// Data bit index within a frame
	typedef logic [$clog2(DATA_BITS)-1:0] bit_cnt_t;

	// Received byte, valid is a one-cycle pulse
	typedef struct packed {
		logic       valid;
		uart_byte_t data;
	} rx_byte_s;

	// Transmit request, four-phase with a separate ack
	typedef struct packed {
		logic       req;
		uart_byte_t data;
	} tx_req_s;

endpackage

/* hdl/rng_pkg.sv */
package rng_pkg;

	////////////////////
	// Generator

	typedef logic [31:0] rng_word_t;

	// State after reset and after reseed
	localparam rng_word_t LFSR_SEED = 32'hACE12468;
	// Galois feedback mask
	localparam rng_word_t LFSR_TAPS = 32'h80200003;
	// LFSR steps per requested word
	localparam int WARMUP_STEPS = 16;
	localparam int BYTES_PER_WORD = 4;

	typedef logic [$clog2(WARMUP_STEPS)-1:0] step_cnt_t;
	typedef logic [$clog2(BYTES_PER_WORD)-1:0] byte_idx_t;

	////////////////////
	// Commands

	localparam logic [7:0] CMD_GENERATE = 8'h31;
	localparam logic [7:0] CMD_RESEED   = 8'h52;

	// Controller FSM
	typedef enum logic [2:0] {
		IDLE,
		GEN_REQ,
		GEN_RELEASE,
		TX_REQ,
		TX_RELEASE,
		RESEED
	} ctrl_state_e;

endpackage

/* hdl/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
	input  logic               i_Clk,
	input  logic               arst_n,
	input  logic               rx,
	output uart_pkg::rx_byte_s rx_byte
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e           state;
	uart_pkg::baud_cnt_t cnt;
	uart_pkg::bit_cnt_t  bit_cnt;
	uart_pkg::uart_byte_t data_q;
	logic                valid_q;
	// Two-flop synchronizer plus one flop for edge detect
	logic                rx_meta;
	logic                rx_s;
	logic                rx_prev;
	logic                bit_tick;
	logic                half_tick;

	always_ff @(posedge i_Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rx_meta <= 1'b1;
			rx_s    <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_s    <= rx_meta;
			rx_prev <= rx_s;
		end
	end

	// End of a full bit, and middle of the start bit
	assign bit_tick  = (cnt == uart_pkg::CLKS_PER_BIT - 1);
	assign half_tick = (cnt == uart_pkg::CLKS_PER_BIT / 2 - 1);

	////////////////////
	// Frame FSM

	always_ff @(posedge i_Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= RX_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			// Pulse only
			valid_q <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					cnt <= '0;
					// Falling edge of start bit
					if (rx_prev && !rx_s)
						state <= RX_START;
				end
				RX_START:
				begin
					if (half_tick)
					begin
						cnt     <= '0;
						bit_cnt <= '0;
						// Glitch, back to idle
						state   <= rx_s ? RX_IDLE : RX_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				end
				RX_DATA:
				begin
					cnt <= cnt + 1'b1;
					if (bit_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == uart_pkg::DATA_BITS - 1)
							state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					cnt <= cnt + 1'b1;
					if (bit_tick)
					begin
						// Bad stop bit drops the frame
						valid_q <= rx_s;
						state   <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data bits sampled at bit centre, LSB first
	always_ff @(posedge i_Clk)
	begin
		if (state == RX_DATA && bit_tick)
			data_q <= {rx_s, data_q[uart_pkg::DATA_BITS-1:1]};
	end

	assign rx_byte = '{valid: valid_q, data: data_q};

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
	input  logic              i_Clk,
	input  logic              arst_n,
	input  uart_pkg::tx_req_s tx_req,
	output logic              tx_ack,
	output logic              tx
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP,
		TX_ACK
	} tx_state_e;

	tx_state_e            state;
	uart_pkg::baud_cnt_t  cnt;
	uart_pkg::bit_cnt_t   bit_cnt;
	uart_pkg::uart_byte_t shreg;
	logic                 bit_tick;

	assign bit_tick = (cnt == uart_pkg::CLKS_PER_BIT - 1);

	always_ff @(posedge i_Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= TX_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			shreg   <= '0;
			tx      <= 1'b1;
			tx_ack  <= 1'b0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					cnt <= '0;
					if (tx_req.req)
					begin
						// Latch byte and begin start bit
						shreg <= tx_req.data;
						tx    <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START:
				begin
					cnt <= cnt + 1'b1;
					if (bit_tick)
					begin
						tx      <= shreg[0];
						shreg   <= shreg >> 1;
						bit_cnt <= '0;
						state   <= TX_DATA;
					end
				end
				TX_DATA:
				begin
					cnt <= cnt + 1'b1;
					if (bit_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == uart_pkg::DATA_BITS - 1)
						begin
							tx    <= 1'b1;
							state <= TX_STOP;
						end
						else
						begin
							tx    <= shreg[0];
							shreg <= shreg >> 1;
						end
					end
				end
				TX_STOP:
				begin
					cnt <= cnt + 1'b1;
					// Stop bit done, frame complete
					if (bit_tick)
					begin
						tx_ack <= 1'b1;
						state  <= TX_ACK;
					end
				end
				TX_ACK:
				begin
					// Hold ack until req drops
					if (!tx_req.req)
					begin
						tx_ack <= 1'b0;
						state  <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Byte must not move under an open request
	a_data_stable: assert property (@(posedge i_Clk) disable iff (!arst_n)
		tx_req.req && $past(tx_req.req) && !tx_ack |-> $stable(tx_req.data))
		else $error("uart_tx: data changed during request");

endmodule

/* hdl/prng_core.sv */
`timescale 1ns/100ps

module prng_core (
	input  logic              i_Clk,
	input  logic              arst_n,
	input  logic              gen_req,
	input  logic              reseed,
	output logic              gen_ack,
	output rng_pkg::rng_word_t gen_word
);

	typedef enum logic [1:0] {
		G_IDLE,
		G_RUN,
		G_ACK
	} gen_state_e;

	gen_state_e          state;
	rng_pkg::rng_word_t  lfsr_q;
	rng_pkg::step_cnt_t  step_cnt;

	// One Galois step, shift right and fold in taps on a 1 out
	function automatic rng_pkg::rng_word_t lfsr_step(input rng_pkg::rng_word_t s);
		return s[0] ? ((s >> 1) ^ rng_pkg::LFSR_TAPS) : (s >> 1);
	endfunction

	always_ff @(posedge i_Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= G_IDLE;
			lfsr_q   <= rng_pkg::LFSR_SEED;
			step_cnt <= '0;
			gen_ack  <= 1'b0;
		end
		else if (reseed)
			lfsr_q <= rng_pkg::LFSR_SEED;
		else
		begin
			case (state)
				G_IDLE:
				begin
					step_cnt <= '0;
					if (gen_req)
						state <= G_RUN;
				end
				G_RUN:
				begin
					lfsr_q   <= lfsr_step(lfsr_q);
					step_cnt <= step_cnt + 1'b1;
					// Ack lands with the last step
					if (step_cnt == rng_pkg::WARMUP_STEPS - 1)
					begin
						gen_ack <= 1'b1;
						state   <= G_ACK;
					end
				end
				G_ACK:
				begin
					if (!gen_req)
					begin
						gen_ack <= 1'b0;
						state   <= G_IDLE;
					end
				end
				default: state <= G_IDLE;
			endcase
		end
	end

	// Word frozen while ack is up
	assign gen_word = lfsr_q;

	a_no_reseed_in_req: assert property (@(posedge i_Clk) disable iff (!arst_n)
		reseed |-> !gen_req)
		else $error("prng_core: reseed during request");

	a_ack_needs_req: assert property (@(posedge i_Clk) disable iff (!arst_n)
		$rose(gen_ack) |-> gen_req)
		else $error("prng_core: ack without request");

endmodule

/* hdl/rng_controller.sv */
`timescale 1ns/100ps

module rng_controller (
	input  logic               i_Clk,
	input  logic               arst_n,
	input  uart_pkg::rx_byte_s rx_byte,
	input  logic               gen_ack,
	input  rng_pkg::rng_word_t gen_word,
	input  logic               tx_ack,
	output logic               gen_req,
	output logic               reseed,
	output uart_pkg::tx_req_s  tx_req,
	output logic               busy_led
);

	rng_pkg::ctrl_state_e state;
	rng_pkg::rng_word_t   word_q;
	rng_pkg::byte_idx_t   byte_idx;
	logic                 req_q;

	////////////////////
	// Sequencer

	always_ff @(posedge i_Clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state    <= rng_pkg::IDLE;
			gen_req  <= 1'b0;
			reseed   <= 1'b0;
			req_q    <= 1'b0;
			byte_idx <= '0;
		end
		else
		begin
			case (state)
				rng_pkg::IDLE:
				begin
					// Only place where commands are taken
					if (rx_byte.valid)
					begin
						if (rx_byte.data == rng_pkg::CMD_GENERATE)
						begin
							gen_req <= 1'b1;
							state   <= rng_pkg::GEN_REQ;
						end
						else if (rx_byte.data == rng_pkg::CMD_RESEED)
						begin
							reseed <= 1'b1;
							state  <= rng_pkg::RESEED;
						end
					end
				end
				rng_pkg::RESEED:
				begin
					// Single-cycle pulse with no response
					reseed <= 1'b0;
					state  <= rng_pkg::IDLE;
				end
				rng_pkg::GEN_REQ:
				begin
					if (gen_ack)
					begin
						gen_req <= 1'b0;
						state   <= rng_pkg::GEN_RELEASE;
					end
				end
				rng_pkg::GEN_RELEASE:
				begin
					// Wait for generator to close handshake
					if (!gen_ack)
					begin
						byte_idx <= '0;
						req_q    <= 1'b1;
						state    <= rng_pkg::TX_REQ;
					end
				end
				rng_pkg::TX_REQ:
				begin
					if (tx_ack)
					begin
						req_q <= 1'b0;
						state <= rng_pkg::TX_RELEASE;
					end
				end
				rng_pkg::TX_RELEASE:
				begin
					if (!tx_ack)
					begin
						// Word done after the last byte
						if (byte_idx == rng_pkg::BYTES_PER_WORD - 1)
							state <= rng_pkg::IDLE;
						else
						begin
							byte_idx <= byte_idx + 1'b1;
							req_q    <= 1'b1;
							state    <= rng_pkg::TX_REQ;
						end
					end
				end
				default: state <= rng_pkg::IDLE;
			endcase
		end
	end

	// Capture word at end of generator handshake
	always_ff @(posedge i_Clk)
	begin
		if (state == rng_pkg::GEN_REQ && gen_ack)
			word_q <= gen_word;
	end

	// LSB first
	// Byte select only moves while req is low
	assign tx_req = '{req: req_q, data: word_q[8*byte_idx +: 8]};

	assign busy_led = (state != rng_pkg::IDLE);

	// New request only once the previous ack has closed
	a_req_after_ack_low: assert property (@(posedge i_Clk) disable iff (!arst_n)
		$rose(tx_req.req) |-> !tx_ack)
		else $error("rng_controller: tx req raised while ack still high");

endmodule

/* hdl/rng_uart_top.sv */
`timescale 1ns/100ps

module rng_uart_top (
	input  logic i_Clk,
	input  logic arst_n,
	input  logic rx,
	output logic tx,
	output logic busy_led
);

	uart_pkg::rx_byte_s rx_byte;
	uart_pkg::tx_req_s  tx_req;
	rng_pkg::rng_word_t gen_word;
	logic               gen_req;
	logic               gen_ack;
	logic               reseed;
	logic               tx_ack;

	////////////////////
	// Input side

	uart_rx uart_rx_i (
		.i_Clk   (i_Clk),
		.arst_n  (arst_n),
		.rx      (rx),
		.rx_byte (rx_byte)
	);

	// Command decode and sequencing
	rng_controller rng_controller_i (
		.i_Clk    (i_Clk),
		.arst_n   (arst_n),
		.rx_byte  (rx_byte),
		.gen_ack  (gen_ack),
		.gen_word (gen_word),
		.tx_ack   (tx_ack),
		.gen_req  (gen_req),
		.reseed   (reseed),
		.tx_req   (tx_req),
		.busy_led (busy_led)
	);

	prng_core prng_core_i (
		.i_Clk    (i_Clk),
		.arst_n   (arst_n),
		.gen_req  (gen_req),
		.reseed   (reseed),
		.gen_ack  (gen_ack),
		.gen_word (gen_word)
	);

	////////////////////
	// Output side

	uart_tx uart_tx_i (
		.i_Clk  (i_Clk),
		.arst_n (arst_n),
		.tx_req (tx_req),
		.tx_ack (tx_ack),
		.tx     (tx)
	);

endmodule

/* verif/rng_checker.sv */
`timescale 1ns/100ps

module rng_checker (
	input  logic i_Clk,
	input  logic arst_n,
	input  logic tx,
	input  logic busy_led,
	output int   mismatch_errs,
	output int   frame_errs,
	output int   status_errs
);

	// Expected words, oldest first, with the test that asked for each
	rng_pkg::rng_word_t   exp_words[$];
	string                exp_names[$];
	rng_pkg::rng_word_t   got_word;
	uart_pkg::uart_byte_t got_byte;
	int                   byte_cnt;
	logic                 tx_prev;
	logic                 stop_bit;

	task automatic add_expected(input rng_pkg::rng_word_t w, input string name);
		exp_words.push_back(w);
		exp_names.push_back(name);
	endtask

	// Words still owed by the DUT
	function automatic int pending();
		return exp_words.size();
	endfunction

	// Status LED must be dark with nothing in flight
	task automatic check_idle(input string where);
		@(negedge i_Clk);
		if (busy_led !== 1'b0)
		begin
			status_errs++;
			$display("busy_led is high %s although no command is in progress", where);
		end
	endtask

	////////////////////
	// Frame decoder

	initial
	begin
		mismatch_errs = 0;
		frame_errs    = 0;
		status_errs   = 0;
		byte_cnt      = 0;
		tx_prev       = 1'b1;
		forever
		begin
			@(posedge i_Clk);
			if (arst_n && tx_prev && !tx)
			begin
				// Move to start bit centre
				repeat (uart_pkg::CLKS_PER_BIT / 2 - 1) @(posedge i_Clk);
				if (busy_led !== 1'b1)
				begin
					status_errs++;
					$display("busy_led is low while a response frame is on tx");
				end
				// Data bits, LSB first
				for (int i = 0; i < uart_pkg::DATA_BITS; i++)
				begin
					repeat (uart_pkg::CLKS_PER_BIT) @(posedge i_Clk);
					got_byte[i] = tx;
				end
				repeat (uart_pkg::CLKS_PER_BIT) @(posedge i_Clk);
				stop_bit = tx;
				if (!stop_bit)
				begin
					frame_errs++;
					$display("Response frame 0x%02h has a low stop bit", got_byte);
				end
				else if (exp_words.size() == 0)
				begin
					frame_errs++;
					$display("Output frame 0x%02h arrived with no word expected", got_byte);
				end
				else
				begin
					// Bytes fill the word from the low end
					got_word[8*byte_cnt +: 8] = got_byte;
					byte_cnt++;
					if (byte_cnt == rng_pkg::BYTES_PER_WORD)
					begin
						byte_cnt = 0;
						if (got_word !== exp_words[0])
						begin
							mismatch_errs++;
							$display("ERROR %s: expected 0x%08h actual 0x%08h",
								exp_names[0], exp_words[0], got_word);
						end
						void'(exp_words.pop_front());
						void'(exp_names.pop_front());
					end
				end
			end
			tx_prev = tx;
		end
	end

endmodule

/* verif/tb_rng_uart.sv */
`timescale 1ns/100ps

module tb_rng_uart;

	// Cycle limit is twice about 12 commands of 900 cycles each
	localparam int NUM_CMDS   = 12;
	localparam int CMD_CYCLES = 900;
	localparam int MAX_CYCLES = 2 * NUM_CMDS * CMD_CYCLES;

	logic               i_Clk;
	logic               arst_n;
	logic               rx;
	logic               tx;
	logic               busy_led;
	int                 cycles = 0;
	int                 mismatch_errs;
	int                 frame_errs;
	int                 status_errs;
	// Model of the generator state
	rng_pkg::rng_word_t model_state;

	rng_uart_top rng_uart_top_i (
		.i_Clk    (i_Clk),
		.arst_n   (arst_n),
		.rx       (rx),
		.tx       (tx),
		.busy_led (busy_led)
	);

	rng_checker rng_checker_i (
		.i_Clk         (i_Clk),
		.arst_n        (arst_n),
		.tx            (tx),
		.busy_led      (busy_led),
		.mismatch_errs (mismatch_errs),
		.frame_errs    (frame_errs),
		.status_errs   (status_errs)
	);

	initial
	begin
		i_Clk = 1'b0;
		forever #5 i_Clk = ~i_Clk;
	end

	always @(posedge i_Clk)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles, DUT never finished", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// Reference model

	// Galois LFSR run for one word's worth of steps
	function automatic rng_pkg::rng_word_t ref_word(input rng_pkg::rng_word_t s);
		rng_pkg::rng_word_t r;
		logic               out_bit;
		r = s;
		for (int i = 0; i < rng_pkg::WARMUP_STEPS; i++)
		begin
			// Bit falling off the low end decides the feedback
			out_bit = r[0];
			r       = r >> 1;
			if (out_bit)
				r = r ^ rng_pkg::LFSR_TAPS;
		end
		return r;
	endfunction

	// Start bit then 8 data bits LSB first then stop bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(posedge i_Clk);
			rx <= frame[i];
			repeat (uart_pkg::CLKS_PER_BIT - 1) @(posedge i_Clk);
		end
	endtask

	task automatic request_word(input string name);
		model_state = ref_word(model_state);
		rng_checker_i.add_expected(model_state, name);
		send_byte(rng_pkg::CMD_GENERATE);
	endtask

	// All words out and FSM back home
	task automatic wait_idle();
		do
			@(posedge i_Clk);
		while (rng_checker_i.pending() != 0 || busy_led);
		repeat (20) @(posedge i_Clk);
	endtask

	task automatic idle_gap();
		repeat ($urandom_range(40, 5)) @(posedge i_Clk);
	endtask

	initial
	begin
		logic [7:0] filler;
		void'($urandom(73183));
		rx          <= 1'b1;
		arst_n      <= 1'b0;
		model_state = rng_pkg::LFSR_SEED;
		repeat (16) @(posedge i_Clk);
		arst_n <= 1'b1;
		rng_checker_i.check_idle("after reset");

		// First word from seed
		request_word("first_word");
		wait_idle();
		// Sequence continues across requests
		for (int i = 0; i < 3; i++)
		begin
			request_word("sequence");
			wait_idle();
			idle_gap();
		end
		// Reseed gives the first word again
		send_byte(rng_pkg::CMD_RESEED);
		model_state = rng_pkg::LFSR_SEED;
		idle_gap();
		rng_checker_i.check_idle("after reseed");
		request_word("after_reseed");
		wait_idle();
		// Unknown bytes give no output and no step
		for (int i = 0; i < 4; i++)
		begin
			do
				filler = $urandom_range(255, 0);
			while (filler == rng_pkg::CMD_GENERATE || filler == rng_pkg::CMD_RESEED);
			send_byte(filler);
			idle_gap();
			rng_checker_i.check_idle("after a filler byte");
		end
		request_word("after_filler");
		wait_idle();
		// Second command lands during the response and is lost
		request_word("overlap_first");
		while (tx)
			@(posedge i_Clk);
		send_byte(rng_pkg::CMD_GENERATE);
		wait_idle();
		request_word("after_overlap");
		wait_idle();
		repeat (200) @(posedge i_Clk);

		$display("Errors: %0d word mismatches, %0d frame errors, %0d status errors",
			mismatch_errs, frame_errs, status_errs);
		if (mismatch_errs + frame_errs + status_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* filelist.f */
hdl/uart_pkg.sv
hdl/rng_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/prng_core.sv
hdl/rng_controller.sv
hdl/rng_uart_top.sv
verif/rng_checker.sv
verif/tb_rng_uart.sv
